//--- rtl/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// Major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// funct3 codes
`define F3_ADD_SUB  3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_WORD     3'b010

// funct7 code
`define F7_SUB      7'b0100000

// Data-bus wait limit in cycles
`define BUS_TIMEOUT_CYCLES 16

`endif

//--- rtl/rv_core_pkg.sv
`include "rv_core_defines.svh"

`default_nettype none

package rv_core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // PASS_B carries the LUI immediate
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        ERROR
    } mem_state_t;

endpackage

interface dec_ex_if import rv_core_pkg::*; ();
    logic     valid;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     branch_ne;
    logic     is_jal;
    logic     wr_reg;

    modport dec (
        output valid, pc, rs1_val, rs2_val, rs1, rs2, rd, imm, alu_op,
        output use_imm, is_load, is_store, is_branch, branch_ne, is_jal, wr_reg
    );
    modport ex (
        input valid, pc, rs1_val, rs2_val, rs1, rs2, rd, imm, alu_op,
        input use_imm, is_load, is_store, is_branch, branch_ne, is_jal, wr_reg
    );
endinterface

interface ex_mem_if import rv_core_pkg::*; ();
    logic     valid;
    word_t    result;
    word_t    store_data;
    reg_idx_t rd;
    logic     is_load;
    logic     is_store;
    logic     wr_reg;

    modport ex (output valid, result, store_data, rd, is_load, is_store, wr_reg);
    modport mem (input valid, result, store_data, rd, is_load, is_store, wr_reg);
endinterface

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none

module fetch_unit import rv_core_pkg::*; (
    input  wire        clk,
    input  wire        i_reset,
    input  wire        i_acki_n,
    input  wire word_t i_idt,
    input  wire        i_hold,
    input  wire        i_stall,
    input  wire        i_redirect,
    input  wire word_t i_redirect_pc,
    output word_t      o_iad,
    output logic       o_if_valid,
    output word_t      o_if_pc,
    output word_t      o_if_instr
);

    word_t pc;
    logic  advance;

    assign o_iad   = pc;
    assign advance = !i_hold && !i_stall && !i_acki_n;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc <= '0;
        end else if (i_redirect) begin
            pc <= i_redirect_pc;
        end else if (advance) begin
            pc <= pc + word_t'(4);
        end
    end

    // Bubble into decode on redirect or while the fetch is unacknowledged
    always_ff @(posedge clk) begin
        if (i_reset || i_redirect) begin
            o_if_valid <= 1'b0;
        end else if (!i_hold && !i_stall) begin
            o_if_valid <= !i_acki_n;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            o_if_pc    <= pc;
            o_if_instr <= i_idt;
        end
    end

    // Redirect targets come from execute
    assert property (@(posedge clk) disable iff (i_reset) o_iad[1:0] == 2'b00)
        else $error("instruction address not word aligned");

endmodule

`default_nettype wire

//--- rtl/decode_unit.sv
`include "rv_core_defines.svh"

`default_nettype none

module decode_unit import rv_core_pkg::*; (
    input  wire           clk,
    input  wire           i_reset,
    input  wire           i_hold,
    input  wire           i_redirect,
    input  wire           i_if_valid,
    input  wire word_t    i_if_pc,
    input  wire word_t    i_if_instr,
    input  wire           i_wb_en,
    input  wire reg_idx_t i_wb_rd,
    input  wire word_t    i_wb_data,
    output logic          o_load_stall,
    dec_ex_if.dec         d
);

    word_t      regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       f3_known;
    word_t      imm;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       branch_ne;
    logic       is_jal;
    logic       wr_reg;
    logic       uses_rs1;
    logic       uses_rs2;
    word_t      rs1_val;
    word_t      rs2_val;

    function automatic alu_op_t f3_to_alu(input logic [2:0] f3, input logic sub);
        alu_op_t op;
        case (f3)
            `F3_SLT: op = SLT;
            `F3_XOR: op = XOR;
            `F3_OR:  op = OR;
            `F3_AND: op = AND;
            default: op = sub ? SUB : ADD;
        endcase
        return op;
    endfunction

    assign opcode   = i_if_instr[6:0];
    assign rd       = i_if_instr[11:7];
    assign funct3   = i_if_instr[14:12];
    assign rs1      = i_if_instr[19:15];
    assign rs2      = i_if_instr[24:20];
    assign funct7   = i_if_instr[31:25];
    assign f3_known = funct3 inside {`F3_ADD_SUB, `F3_SLT, `F3_XOR, `F3_OR, `F3_AND};

    // Anything not matched below stays a no-op
    always_comb begin
        imm       = {{20{i_if_instr[31]}}, i_if_instr[31:20]};
        alu_op    = f3_to_alu(funct3, opcode == `OPC_OP && funct7 == `F7_SUB);
        use_imm   = 1'b1;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        wr_reg    = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            `OPC_OP: begin
                use_imm  = 1'b0;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                wr_reg   = f3_known;
            end
            `OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                wr_reg   = f3_known;
            end
            `OPC_LUI: begin
                imm    = {i_if_instr[31:12], 12'b0};
                alu_op = PASS_B;
                wr_reg = 1'b1;
            end
            `OPC_LOAD: begin
                alu_op   = ADD;
                uses_rs1 = 1'b1;
                is_load  = (funct3 == `F3_WORD);
                wr_reg   = is_load;
            end
            `OPC_STORE: begin
                imm      = {{20{i_if_instr[31]}}, i_if_instr[31:25], i_if_instr[11:7]};
                alu_op   = ADD;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                is_store = (funct3 == `F3_WORD);
            end
            `OPC_BRANCH: begin
                imm       = {{19{i_if_instr[31]}}, i_if_instr[31], i_if_instr[7],
                             i_if_instr[30:25], i_if_instr[11:8], 1'b0};
                use_imm   = 1'b0;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                is_branch = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
                branch_ne = (funct3 == `F3_BNE);
            end
            `OPC_JAL: begin
                imm    = {{11{i_if_instr[31]}}, i_if_instr[31], i_if_instr[19:12],
                          i_if_instr[20], i_if_instr[30:21], 1'b0};
                is_jal = 1'b1;
                wr_reg = 1'b1;
            end
            default: begin
            end
        endcase
        if (rd == '0) begin
            wr_reg = 1'b0;
        end
    end

    // Register file, write-first
    assign rs1_val = (rs1 == '0) ? '0 :
                     (i_wb_en && i_wb_rd == rs1) ? i_wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (i_wb_en && i_wb_rd == rs2) ? i_wb_data : regs[rs2];

    always_ff @(posedge clk) begin
        if (i_wb_en && i_wb_rd != '0) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // Load in execute feeding a source here
    assign o_load_stall = i_if_valid && d.valid && d.is_load && d.wr_reg &&
                          ((uses_rs1 && rs1 == d.rd) || (uses_rs2 && rs2 == d.rd));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            d.valid <= 1'b0;
        end else if (!i_hold) begin
            d.valid <= i_if_valid && !i_redirect && !o_load_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            d.pc        <= i_if_pc;
            d.rs1_val   <= rs1_val;
            d.rs2_val   <= rs2_val;
            d.rs1       <= rs1;
            d.rs2       <= rs2;
            d.rd        <= rd;
            d.imm       <= imm;
            d.alu_op    <= alu_op;
            d.use_imm   <= use_imm;
            d.is_load   <= is_load;
            d.is_store  <= is_store;
            d.is_branch <= is_branch;
            d.branch_ne <= branch_ne;
            d.is_jal    <= is_jal;
            d.wr_reg    <= wr_reg;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
`default_nettype none

module execute_unit import rv_core_pkg::*; (
    input  wire           clk,
    input  wire           i_reset,
    input  wire           i_hold,
    dec_ex_if.ex          d,
    input  wire           i_wb_en,
    input  wire reg_idx_t i_wb_rd,
    input  wire word_t    i_wb_data,
    output logic          o_redirect,
    output word_t         o_redirect_pc,
    ex_mem_if.ex          m
);

    logic  mem_fwd_ok;
    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_out;
    word_t pc_plus4;
    logic  taken;

    // A load in memory only has its address so far
    assign mem_fwd_ok = m.valid && m.wr_reg && !m.is_load;

    // Memory stage wins over writeback
    function automatic word_t fwd(input reg_idx_t idx, input word_t dec_val);
        word_t val;
        if (idx != '0 && mem_fwd_ok && m.rd == idx) begin
            val = m.result;
        end else if (idx != '0 && i_wb_en && i_wb_rd == idx) begin
            val = i_wb_data;
        end else begin
            val = dec_val;
        end
        return val;
    endfunction

    always_comb begin
        op_a    = fwd(d.rs1, d.rs1_val);
        rs2_fwd = fwd(d.rs2, d.rs2_val);
        op_b    = d.use_imm ? d.imm : rs2_fwd;
        case (d.alu_op)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            AND:     alu_out = op_a & op_b;
            OR:      alu_out = op_a | op_b;
            XOR:     alu_out = op_a ^ op_b;
            SLT:     alu_out = word_t'($signed(op_a) < $signed(op_b));
            PASS_B:  alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    assign pc_plus4 = d.pc + word_t'(4);
    assign taken    = d.valid &&
                      (d.is_jal || (d.is_branch && ((op_a == rs2_fwd) != d.branch_ne)));

    // Not while held, the branch would redirect again
    assign o_redirect    = taken && !i_hold;
    assign o_redirect_pc = d.pc + d.imm;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            m.valid <= 1'b0;
        end else if (!i_hold) begin
            m.valid <= d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            m.result     <= d.is_jal ? pc_plus4 : alu_out;
            m.store_data <= rs2_fwd;
            m.rd         <= d.rd;
            m.is_load    <= d.is_load;
            m.is_store   <= d.is_store;
            m.wr_reg     <= d.wr_reg;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_access_fsm.sv
`default_nettype none

module mem_access_fsm import rv_core_pkg::*; (
    input  wire        clk,
    input  wire        i_reset,
    ex_mem_if.mem      m,
    input  wire        i_ackd_n,
    input  wire word_t i_drdata,
    input  wire        i_timeout,
    output word_t      o_dad,
    output word_t      o_dwdata,
    output logic       o_mreq,
    output logic       o_write,
    output logic       o_busy,
    output logic       o_bus_error,
    output logic       o_wb_en,
    output reg_idx_t   o_wb_rd,
    output word_t      o_wb_data
);

    mem_state_t state;
    mem_state_t state_next;
    logic       mem_op;

    assign mem_op = m.valid && (m.is_load || m.is_store);

    // Request goes out on the first cycle, ACCESS covers the wait
    always_comb begin
        case (state)
            IDLE, ACCESS: begin
                if (i_timeout) begin
                    state_next = ERROR;
                end else if (mem_op && i_ackd_n) begin
                    state_next = ACCESS;
                end else begin
                    state_next = IDLE;
                end
            end
            default: state_next = ERROR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign o_mreq      = mem_op && (state != ERROR);
    assign o_write     = o_mreq && m.is_store;
    assign o_dad       = m.result;
    assign o_dwdata    = m.store_data;
    assign o_busy      = (state == ERROR) || (mem_op && i_ackd_n);
    assign o_bus_error = (state == ERROR);

    // Held with the rest so forwarding stays consistent
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_en <= 1'b0;
        end else if (!o_busy) begin
            o_wb_en <= m.valid && m.wr_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!o_busy) begin
            o_wb_rd   <= m.rd;
            o_wb_data <= m.is_load ? i_drdata : m.result;
        end
    end

    // ACCESS only while the same request is still out
    assert property (@(posedge clk) disable iff (i_reset)
        state == ACCESS |-> o_mreq && $stable(o_dad));

    // A write keeps its request and address until acknowledged
    assert property (@(posedge clk) disable iff (i_reset)
        o_write && i_ackd_n && !i_timeout |=> o_write && o_mreq && $stable(o_dad));

endmodule

`default_nettype wire

//--- rtl/bus_wait_timer.sv
`include "rv_core_defines.svh"

`default_nettype none

module bus_wait_timer (
    input  wire  clk,
    input  wire  i_reset,
    input  wire  i_mreq,
    input  wire  i_ackd_n,
    output logic o_timeout
);

    localparam int LIMIT = `BUS_TIMEOUT_CYCLES;
    localparam int CNT_W = $clog2(LIMIT + 1);

    logic [CNT_W-1:0] wait_cnt;
    logic             waiting;

    assign waiting = i_mreq && i_ackd_n;

    always_ff @(posedge clk) begin
        if (i_reset || !waiting) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + CNT_W'(1);
        end
    end

    // Fires on the last allowed waiting cycle
    assign o_timeout = waiting && (wait_cnt == CNT_W'(LIMIT - 1));

    // The request has to drop once the limit is reached
    assert property (@(posedge clk) disable iff (i_reset) wait_cnt <= CNT_W'(LIMIT));

endmodule

`default_nettype wire

//--- rtl/rv_core_top.sv
`default_nettype none

module rv_core_top import rv_core_pkg::*; (
    input  wire        clk,
    input  wire        i_reset,

    // Instruction bus
    output word_t      o_iad,
    input  wire word_t i_idt,
    input  wire        i_acki_n,

    // Data bus
    output word_t      o_dad,
    output word_t      o_dwdata,
    input  wire word_t i_drdata,
    input  wire        i_ackd_n,
    output logic       o_mreq,
    output logic       o_write,
    output logic       o_bus_error
);

    dec_ex_if dec_ex ();
    ex_mem_if ex_mem ();

    logic     if_valid;
    word_t    if_pc;
    word_t    if_instr;
    logic     load_stall;
    logic     redirect;
    word_t    redirect_pc;
    logic     mem_busy;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     timeout;

    fetch_unit fetch_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_acki_n      (i_acki_n),
        .i_idt         (i_idt),
        .i_hold        (mem_busy),
        .i_stall       (load_stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_iad         (o_iad),
        .o_if_valid    (if_valid),
        .o_if_pc       (if_pc),
        .o_if_instr    (if_instr)
    );

    decode_unit decode_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_hold       (mem_busy),
        .i_redirect   (redirect),
        .i_if_valid   (if_valid),
        .i_if_pc      (if_pc),
        .i_if_instr   (if_instr),
        .i_wb_en      (wb_en),
        .i_wb_rd      (wb_rd),
        .i_wb_data    (wb_data),
        .o_load_stall (load_stall),
        .d            (dec_ex.dec)
    );

    execute_unit execute_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_hold        (mem_busy),
        .d             (dec_ex.ex),
        .i_wb_en       (wb_en),
        .i_wb_rd       (wb_rd),
        .i_wb_data     (wb_data),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .m             (ex_mem.ex)
    );

    mem_access_fsm mem_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .m           (ex_mem.mem),
        .i_ackd_n    (i_ackd_n),
        .i_drdata    (i_drdata),
        .i_timeout   (timeout),
        .o_dad       (o_dad),
        .o_dwdata    (o_dwdata),
        .o_mreq      (o_mreq),
        .o_write     (o_write),
        .o_busy      (mem_busy),
        .o_bus_error (o_bus_error),
        .o_wb_en     (wb_en),
        .o_wb_rd     (wb_rd),
        .o_wb_data   (wb_data)
    );

    bus_wait_timer timer_inst (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_mreq    (o_mreq),
        .i_ackd_n  (i_ackd_n),
        .o_timeout (timeout)
    );

endmodule

`default_nettype wire

//--- dv/rv_core_tb.sv
`include "rv_core_defines.svh"

`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

    localparam int STORE_TIMEOUT = 2000;
    localparam int REQ_TIMEOUT   = 200;
    localparam int HALT_CYCLES   = 50;

    logic  clk;
    logic  i_reset;
    logic  i_acki_n;
    logic  i_ackd_n;
    word_t i_idt;
    word_t i_drdata;
    word_t o_iad;
    word_t o_dad;
    word_t o_dwdata;
    logic  o_mreq;
    logic  o_write;
    logic  o_bus_error;

    word_t imem [64];
    word_t dmem [64];
    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    word_t t_addr;
    int    prog_len = 0;
    int    store_count = 0;
    int    iwait = 0;
    int    dwait = -1;

    // Data bus as seen at the last falling edge
    logic  req_s;
    logic  write_s;
    word_t dad_s;
    word_t wdata_s;

    rv_core_top UUT (
        .clk         (clk),
        .i_reset     (i_reset),
        .o_iad       (o_iad),
        .i_idt       (i_idt),
        .i_acki_n    (i_acki_n),
        .o_dad       (o_dad),
        .o_dwdata    (o_dwdata),
        .i_drdata    (i_drdata),
        .i_ackd_n    (i_ackd_n),
        .o_mreq      (o_mreq),
        .o_write     (o_write),
        .o_bus_error (o_bus_error)
    );

    // Instruction memory reads like an async ROM, only the ack is delayed
    assign i_idt = imem[o_iad[7:2]];

    task automatic abort_run(input string why);
        $display("RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            abort_run("data word mismatch");
        end
    endtask

    task automatic check_addr(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            abort_run("address mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            abort_run("control output mismatch");
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    n;
        byte   tag;
        string line;
        string rest;
        word_t a;
        word_t w;
        fd = $fopen("dv/rv_core_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/rv_core_golden.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 3) begin
                continue;
            end
            tag  = line.getc(0);
            rest = line.substr(2, line.len() - 1);
            if (tag == "P") begin
                n = $sscanf(rest, "%h", w);
                if (n != 1 || prog_len >= 64) begin
                    abort_run("bad or excess program line in golden file");
                end
                imem[prog_len[5:0]] = w;
                prog_len++;
            end else if (tag == "S") begin
                n = $sscanf(rest, "%h %h", a, w);
                if (n != 2) begin
                    abort_run("bad store line in golden file");
                end
                exp_addr_q.push_back(a);
                exp_data_q.push_back(w);
            end else if (tag == "T") begin
                n = $sscanf(rest, "%h", a);
                if (n != 1) begin
                    abort_run("bad timeout line in golden file");
                end
                t_addr = a;
            end
        end
        $fclose(fd);
    endtask

    task automatic record_store(input word_t addr, input word_t data);
        string name;
        name = $sformatf("store %0d", store_count);
        if (exp_addr_q.size() == 0) begin
            abort_run("store seen beyond the last expected store");
        end
        check_addr(name, exp_addr_q.pop_front(), addr);
        check_word(name, exp_data_q.pop_front(), data);
        dmem[addr[7:2]] = data;
        store_count++;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        req_s   = o_mreq;
        write_s = o_write;
        dad_s   = o_dad;
        wdata_s = o_dwdata;
        if (!i_reset && !i_acki_n && o_iad >= word_t'(prog_len * 4)) begin
            abort_run("instruction fetch outside the loaded program");
        end
    end

    // Both bus models, so random draws keep one order
    always @(posedge clk) begin
        if (i_reset) begin
            i_acki_n <= 1'b1;
            i_ackd_n <= 1'b1;
            iwait = 0;
            dwait = -1;
        end else begin
            if (iwait == 0) begin
                i_acki_n <= 1'b0;
                iwait = int'($urandom % 4);
            end else begin
                i_acki_n <= 1'b1;
                iwait = iwait - 1;
            end
            if (!i_ackd_n) begin
                // Access completes at this edge
                i_ackd_n <= 1'b1;
                if (write_s) begin
                    record_store(dad_s, wdata_s);
                end
            end else if (req_s && dad_s != t_addr) begin
                if (dad_s > word_t'(32'hfc)) begin
                    abort_run("data access outside the memory model");
                end
                if (dwait < 0) begin
                    dwait = int'($urandom % 4);
                end
                if (dwait == 0) begin
                    i_ackd_n <= 1'b0;
                    i_drdata <= dmem[dad_s[7:2]];
                    dwait = -1;
                end else begin
                    dwait = dwait - 1;
                end
            end
        end
    end

    initial begin
        int cycles;
        int n_expected;
        void'($urandom(32'h6a51_934b));
        i_reset  = 1'b1;
        i_acki_n = 1'b1;
        i_ackd_n = 1'b1;
        i_drdata = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i[5:0]] = 32'hda7a_0000 ^ word_t'(i * 4);
        end
        load_golden();
        n_expected = exp_addr_q.size();

        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i == 2) begin
                i_reset <= 1'b0;
            end
            @(negedge clk);
            check_flag($sformatf("reset %0d o_mreq", i), 1'b0, o_mreq);
            check_flag($sformatf("reset %0d o_write", i), 1'b0, o_write);
            check_flag($sformatf("reset %0d o_bus_error", i), 1'b0, o_bus_error);
            check_addr($sformatf("reset %0d o_iad", i), '0, o_iad);
        end

        cycles = 0;
        while (store_count < n_expected) begin
            @(negedge clk);
            cycles++;
            if (cycles > STORE_TIMEOUT) begin
                abort_run("expected stores did not all complete in time");
            end
        end

        cycles = 0;
        while (!(o_mreq && o_dad == t_addr)) begin
            @(negedge clk);
            cycles++;
            if (cycles > REQ_TIMEOUT) begin
                abort_run("store to the timeout address never appeared");
            end
        end
        check_flag("timeout store o_write", 1'b1, o_write);

        // Unacknowledged request must end in a bus error
        cycles = 0;
        while (!o_bus_error) begin
            @(negedge clk);
            cycles++;
            if (cycles > `BUS_TIMEOUT_CYCLES + 2) begin
                abort_run("o_bus_error did not rise within the bus timeout limit");
            end
        end

        repeat (HALT_CYCLES) begin
            @(negedge clk);
            check_flag("halt o_mreq", 1'b0, o_mreq);
            check_flag("halt o_bus_error", 1'b1, o_bus_error);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/rv_core_golden.txt
# P <instruction word>, loaded from address 0 upward
# S <store address> <store data> in order; T <address whose store is never acknowledged>
# ALU chain with forwarding
P 00500093 addi x1, x0, 5
P 00708113 addi x2, x1, 7
P 002081b3 add x3, x1, x2
P 40118233 sub x4, x3, x1
P 0ff24293 xori x5, x4, 0xff
P 12345337 lui x6, 0x12345
P 005363b3 or x7, x6, x5
P 00322433 slt x8, x4, x3
P fff0a493 slti x9, x1, -1
P 7f03f513 andi x10, x7, 0x7f0
P 1234e593 ori x11, x9, 0x123
P 0075f633 and x12, x11, x7
P 04302023 sw x3, 0x40(x0)
P 04702223 sw x7, 0x44(x0)
P 04802423 sw x8, 0x48(x0)
P 04902623 sw x9, 0x4c(x0)
P 04a02823 sw x10, 0x50(x0)
P 04c02a23 sw x12, 0x54(x0)
# Load-use, second load reads the fill at 0x80
P 04002683 lw x13, 0x40(x0)
P 00168733 add x14, x13, x1
P 04e02c23 sw x14, 0x58(x0)
P 08002783 lw x15, 0x80(x0)
P 04f02e23 sw x15, 0x5c(x0)
# Branches and JAL, stores to 0x7c are on squashed paths
P 00208463 beq x1, x2, +8
P 00100813 addi x16, x0, 1
P 00209463 bne x1, x2, +8
P 06102e23 sw x1, 0x7c(x0)
P 00220463 beq x4, x2, +8
P 06202e23 sw x2, 0x7c(x0)
P 00221463 bne x4, x2, +8
P 00280813 addi x16, x16, 2
P 00c008ef jal x17, +12
P 06102e23 sw x1, 0x7c(x0)
P 06202e23 sw x2, 0x7c(x0)
P 07002023 sw x16, 0x60(x0)
P 07102223 sw x17, 0x64(x0)
# Store that hangs the data bus, then a self loop
P 00001937 lui x18, 0x1
P 00192023 sw x1, 0(x18)
P 0000006f jal x0, 0
P 00000013 nop
P 00000013 nop
S 00000040 00000011
S 00000044 123450f3
S 00000048 00000001
S 0000004c 00000000
S 00000050 000000f0
S 00000054 00000023
S 00000058 00000016
S 0000005c da7a0080
S 00000060 00000003
S 00000064 00000080
T 00001000

//--- rv_core.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/mem_access_fsm.sv
rtl/bus_wait_timer.sv
rtl/rv_core_top.sv
dv/rv_core_tb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb
	./obj_dir/Vrv_core_tb

lint:
	verilator --lint-only --timing --assert -f rv_core.f --top-module rv_core_top

clean:
	rm -rf obj_dir
